//--- cpu_params_pkg.sv
`default_nettype none

package cpu_params_pkg;

    localparam int ROB_ID_W   = 5;  // 32 ROB entries
    localparam int ARCH_REG_W = 5;  // 32 architectural registers
    localparam int PHY_REG_W  = 6;  // 64 physical registers after renaming
    localparam int XLEN       = 32;

    typedef logic [ROB_ID_W-1:0]   rob_id_t;
    typedef logic [ARCH_REG_W-1:0] arch_reg_t;
    typedef logic [PHY_REG_W-1:0]  phy_reg_t;
    typedef logic [XLEN-1:0]       word_t;
    typedef logic [XLEN-1:0]       addr_t;  // Byte address, word aligned for now

endpackage

`default_nettype wire

//--- data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
    parameter int RAM_ADDR_W = 6
) (
    input  logic                      clk,
    input  logic                      en,
    input  lsu_types_pkg::byte_mask_t we,
    input  logic [RAM_ADDR_W-1:0]     addr,
    input  cpu_params_pkg::word_t     wdata,
    output cpu_params_pkg::word_t     rdata
);

    import cpu_params_pkg::*;

    localparam int DEPTH = 1 << RAM_ADDR_W;

    word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < 4; i++) begin
                if (we[i]) begin
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
            rdata <= mem[addr];  // Sees the contents before this edge's write
        end
    end

endmodule

`default_nettype wire

//--- list.f
cpu_params_pkg.sv
lsu_types_pkg.sv
data_ram.sv
lsq.sv
mem_stage.sv
lsu_top.sv
tb_lsu.sv

//--- lsq.sv
`timescale 1ns/1ps
`default_nettype none

module lsq #(
    parameter int LSQ_DEPTH = 8
) (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      ds_valid,
    output logic                      ds_ready,
    input  lsu_types_pkg::lsu_op_t    ds_op,
    input  cpu_params_pkg::rob_id_t   ds_rob_id,
    input  cpu_params_pkg::arch_reg_t ds_rd_arch,
    input  cpu_params_pkg::phy_reg_t  ds_rd_phy,

    input  logic                      agu_valid,
    input  cpu_params_pkg::rob_id_t   agu_rob_id,
    input  cpu_params_pkg::addr_t     agu_addr,
    input  lsu_types_pkg::byte_mask_t agu_mask,
    input  cpu_params_pkg::word_t     agu_wdata,

    output logic                      iss_valid,
    input  logic                      iss_ready,
    output lsu_types_pkg::lsu_op_t    iss_op,
    output cpu_params_pkg::rob_id_t   iss_rob_id,
    output cpu_params_pkg::arch_reg_t iss_rd_arch,
    output cpu_params_pkg::phy_reg_t  iss_rd_phy,
    output cpu_params_pkg::addr_t     iss_addr,
    output lsu_types_pkg::byte_mask_t iss_mask,
    output cpu_params_pkg::word_t     iss_wdata
);

    import cpu_params_pkg::*;
    import lsu_types_pkg::*;

    localparam int LSQ_IDX = $clog2(LSQ_DEPTH);

    typedef struct packed {
        logic       valid;  // Slot holds a dispatched op
        logic       ready;  // Address, mask and data have arrived from the AGU
        lsu_op_t    op;
        rob_id_t    rob_id;
        arch_reg_t  rd_arch;
        phy_reg_t   rd_phy;
        addr_t      addr;
        byte_mask_t mask;
        word_t      wdata;
    } lsq_entry_t;

    lsq_entry_t fifo [LSQ_DEPTH];

    // Extra top bit tells a wrapped pointer apart when the indices match
    logic [LSQ_IDX:0]   wr_ptr;
    logic [LSQ_IDX:0]   rd_ptr;
    logic [LSQ_IDX-1:0] wr_idx;
    logic [LSQ_IDX-1:0] rd_idx;

    logic full;
    logic empty;
    logic enqueue;
    logic dequeue;

    logic [LSQ_DEPTH-1:0] agu_hit;

    assign wr_idx = wr_ptr[LSQ_IDX-1:0];
    assign rd_idx = rd_ptr[LSQ_IDX-1:0];

    assign full  = (wr_idx == rd_idx) && (wr_ptr[LSQ_IDX] != rd_ptr[LSQ_IDX]);
    assign empty = (wr_ptr == rd_ptr);

    assign ds_ready = ~full;
    assign enqueue  = ds_valid && ds_ready;

    assign iss_valid = ~empty && fifo[rd_idx].ready;  // Memory order follows program order
    assign dequeue   = iss_valid && iss_ready;

    assign iss_op      = fifo[rd_idx].op;
    assign iss_rob_id  = fifo[rd_idx].rob_id;
    assign iss_rd_arch = fifo[rd_idx].rd_arch;
    assign iss_rd_phy  = fifo[rd_idx].rd_phy;
    assign iss_addr    = fifo[rd_idx].addr;
    assign iss_mask    = fifo[rd_idx].mask;
    assign iss_wdata   = fifo[rd_idx].wdata;

    // Only queued entries still waiting on their address can match
    always_comb begin
        for (int i = 0; i < LSQ_DEPTH; i++) begin
            agu_hit[i] = agu_valid && fifo[i].valid && !fifo[i].ready
                         && (fifo[i].rob_id == agu_rob_id);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            for (int i = 0; i < LSQ_DEPTH; i++) begin
                fifo[i].valid <= 1'b0;
                fifo[i].ready <= 1'b0;
            end
        end else begin
            if (enqueue) begin
                fifo[wr_idx].valid   <= 1'b1;
                fifo[wr_idx].ready   <= 1'b0;
                fifo[wr_idx].op      <= ds_op;
                fifo[wr_idx].rob_id  <= ds_rob_id;
                fifo[wr_idx].rd_arch <= ds_rd_arch;
                fifo[wr_idx].rd_phy  <= ds_rd_phy;
                wr_ptr               <= wr_ptr + 1'b1;
            end
            for (int i = 0; i < LSQ_DEPTH; i++) begin
                if (agu_hit[i]) begin
                    fifo[i].ready <= 1'b1;
                    fifo[i].addr  <= agu_addr;
                    fifo[i].mask  <= agu_mask;
                    fifo[i].wdata <= agu_wdata;
                end
            end
            if (dequeue) begin
                fifo[rd_idx].valid <= 1'b0;  // Head is ready, so no AGU hit can land here
                rd_ptr             <= rd_ptr + 1'b1;
            end
        end
    end

    // Each strobe must name exactly one waiting entry
    agu_match_one: assert property (@(posedge clk) disable iff (rst)
        agu_valid |-> $onehot(agu_hit));

    // The slot behind the write pointer must have been freed by an earlier issue
    enq_slot_free: assert property (@(posedge clk) disable iff (rst)
        enqueue |-> !fifo[wr_idx].valid);

endmodule

`default_nettype wire

//--- lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
    parameter int LSQ_DEPTH  = 8,
    parameter int RAM_ADDR_W = 6
) (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      ds_valid,
    output logic                      ds_ready,
    input  lsu_types_pkg::lsu_op_t    ds_op,
    input  cpu_params_pkg::rob_id_t   ds_rob_id,
    input  cpu_params_pkg::arch_reg_t ds_rd_arch,
    input  cpu_params_pkg::phy_reg_t  ds_rd_phy,

    input  logic                      agu_valid,
    input  cpu_params_pkg::rob_id_t   agu_rob_id,
    input  cpu_params_pkg::addr_t     agu_addr,
    input  lsu_types_pkg::byte_mask_t agu_mask,
    input  cpu_params_pkg::word_t     agu_wdata,

    output logic                      cdb_valid,
    input  logic                      cdb_ready,
    output lsu_types_pkg::lsu_op_t    cdb_op,
    output cpu_params_pkg::rob_id_t   cdb_rob_id,
    output cpu_params_pkg::arch_reg_t cdb_rd_arch,
    output cpu_params_pkg::phy_reg_t  cdb_rd_phy,
    output cpu_params_pkg::word_t     cdb_data
);

    import cpu_params_pkg::*;
    import lsu_types_pkg::*;

    // Queue head to memory stage
    logic       iss_valid;
    logic       iss_ready;
    lsu_op_t    iss_op;
    rob_id_t    iss_rob_id;
    arch_reg_t  iss_rd_arch;
    phy_reg_t   iss_rd_phy;
    addr_t      iss_addr;
    byte_mask_t iss_mask;
    word_t      iss_wdata;

    logic                  ram_en;
    byte_mask_t            ram_we;
    logic [RAM_ADDR_W-1:0] ram_addr;
    word_t                 ram_wdata;
    word_t                 ram_rdata;

    lsq #(
        .LSQ_DEPTH (LSQ_DEPTH)
    ) lsq_inst (
        .clk         (clk),
        .rst         (rst),
        .ds_valid    (ds_valid),
        .ds_ready    (ds_ready),
        .ds_op       (ds_op),
        .ds_rob_id   (ds_rob_id),
        .ds_rd_arch  (ds_rd_arch),
        .ds_rd_phy   (ds_rd_phy),
        .agu_valid   (agu_valid),
        .agu_rob_id  (agu_rob_id),
        .agu_addr    (agu_addr),
        .agu_mask    (agu_mask),
        .agu_wdata   (agu_wdata),
        .iss_valid   (iss_valid),
        .iss_ready   (iss_ready),
        .iss_op      (iss_op),
        .iss_rob_id  (iss_rob_id),
        .iss_rd_arch (iss_rd_arch),
        .iss_rd_phy  (iss_rd_phy),
        .iss_addr    (iss_addr),
        .iss_mask    (iss_mask),
        .iss_wdata   (iss_wdata)
    );

    mem_stage #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) mem_stage_inst (
        .clk         (clk),
        .rst         (rst),
        .iss_valid   (iss_valid),
        .iss_ready   (iss_ready),
        .iss_op      (iss_op),
        .iss_rob_id  (iss_rob_id),
        .iss_rd_arch (iss_rd_arch),
        .iss_rd_phy  (iss_rd_phy),
        .iss_addr    (iss_addr),
        .iss_mask    (iss_mask),
        .iss_wdata   (iss_wdata),
        .ram_en      (ram_en),
        .ram_we      (ram_we),
        .ram_addr    (ram_addr),
        .ram_wdata   (ram_wdata),
        .ram_rdata   (ram_rdata),
        .cdb_valid   (cdb_valid),
        .cdb_ready   (cdb_ready),
        .cdb_op      (cdb_op),
        .cdb_rob_id  (cdb_rob_id),
        .cdb_rd_arch (cdb_rd_arch),
        .cdb_rd_phy  (cdb_rd_phy),
        .cdb_data    (cdb_data)
    );

    data_ram #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) data_ram_inst (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

//--- lsu_types_pkg.sv
`default_nettype none

package lsu_types_pkg;

    localparam int BYTES_PER_WORD = 4;

    // Kind of memory micro-op held in the queue
    typedef enum logic [0:0] {
        LSU_LOAD  = 1'b0,
        LSU_STORE = 1'b1
    } lsu_op_t;

    typedef logic [BYTES_PER_WORD-1:0] byte_mask_t;  // Bit i enables byte i of a word

endpackage

`default_nettype wire

//--- mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage #(
    parameter int RAM_ADDR_W = 6
) (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      iss_valid,
    output logic                      iss_ready,
    input  lsu_types_pkg::lsu_op_t    iss_op,
    input  cpu_params_pkg::rob_id_t   iss_rob_id,
    input  cpu_params_pkg::arch_reg_t iss_rd_arch,
    input  cpu_params_pkg::phy_reg_t  iss_rd_phy,
    input  cpu_params_pkg::addr_t     iss_addr,
    input  lsu_types_pkg::byte_mask_t iss_mask,
    input  cpu_params_pkg::word_t     iss_wdata,

    output logic                      ram_en,
    output lsu_types_pkg::byte_mask_t ram_we,
    output logic [RAM_ADDR_W-1:0]     ram_addr,
    output cpu_params_pkg::word_t     ram_wdata,
    input  cpu_params_pkg::word_t     ram_rdata,

    output logic                      cdb_valid,
    input  logic                      cdb_ready,
    output lsu_types_pkg::lsu_op_t    cdb_op,
    output cpu_params_pkg::rob_id_t   cdb_rob_id,
    output cpu_params_pkg::arch_reg_t cdb_rd_arch,
    output cpu_params_pkg::phy_reg_t  cdb_rd_phy,
    output cpu_params_pkg::word_t     cdb_data
);

    import cpu_params_pkg::*;
    import lsu_types_pkg::*;

    // Slot A, the op whose RAM access is in flight
    logic       a_valid;
    logic       a_fresh;  // RAM output still belongs to this op
    lsu_op_t    a_op;
    rob_id_t    a_rob_id;
    arch_reg_t  a_rd_arch;
    phy_reg_t   a_rd_phy;
    byte_mask_t a_mask;
    word_t      a_hold;

    logic  iss_fire;
    logic  b_free;
    logic  a_move;
    word_t a_rdata;
    word_t a_bytes;

    assign b_free    = !cdb_valid || cdb_ready;  // Slot B is empty or draining this cycle
    assign a_move    = a_valid && b_free;
    assign iss_ready = !a_valid || b_free;
    assign iss_fire  = iss_valid && iss_ready;

    assign ram_en    = iss_fire;
    assign ram_we    = (iss_fire && iss_op == LSU_STORE) ? iss_mask : '0;
    assign ram_addr  = iss_addr[RAM_ADDR_W+1:2];  // Word address, byte offset dropped
    assign ram_wdata = iss_wdata;

    assign a_rdata = a_fresh ? ram_rdata : a_hold;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            a_bytes[8*i +: 8] = a_mask[i] ? a_rdata[8*i +: 8] : 8'h00;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            a_valid   <= 1'b0;
            a_fresh   <= 1'b0;
            cdb_valid <= 1'b0;
        end else begin
            if (iss_fire) begin
                a_valid <= 1'b1;
                a_fresh <= 1'b1;
            end else if (a_move) begin
                a_valid <= 1'b0;
                a_fresh <= 1'b0;
            end else begin
                a_fresh <= 1'b0;  // A stalled op now reads from a_hold
            end
            if (a_move) begin
                cdb_valid <= 1'b1;
            end else if (cdb_ready) begin
                cdb_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (iss_fire) begin
            a_op      <= iss_op;
            a_rob_id  <= iss_rob_id;
            a_rd_arch <= iss_rd_arch;
            a_rd_phy  <= iss_rd_phy;
            a_mask    <= iss_mask;
        end
        if (a_valid && a_fresh && !a_move) begin
            a_hold <= ram_rdata;
        end
        if (a_move) begin
            cdb_op      <= a_op;
            cdb_rob_id  <= a_rob_id;
            cdb_rd_arch <= a_rd_arch;
            cdb_rd_phy  <= a_rd_phy;
            cdb_data    <= (a_op == LSU_LOAD) ? a_bytes : '0;  // Stores carry no result
        end
    end

    cdb_hold_stable: assert property (@(posedge clk) disable iff (rst)
        cdb_valid && !cdb_ready |=> cdb_valid
            && $stable({cdb_op, cdb_rob_id, cdb_rd_arch, cdb_rd_phy, cdb_data}));

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build the LSU testbench with Verilator, run it and judge the log
verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu -f list.f \
    -o tb_lsu_sim > sim.log 2>&1 &&
./obj_dir/tb_lsu_sim >> sim.log 2>&1 &&
! grep -q "tests failed" sim.log &&
echo "PASS" ||
{ echo "FAIL (see sim.log)"; exit 1; }

//--- tb_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsu;

    import cpu_params_pkg::*;
    import lsu_types_pkg::*;

    localparam int LSQ_DEPTH   = 8;
    localparam int RAM_ADDR_W  = 6;
    localparam int RAM_WORDS   = 1 << RAM_ADDR_W;
    localparam int N_RANDOM    = 200;
    localparam int N_STALL     = 150;
    localparam int N_LONE      = 8;
    localparam int TOTAL_OPS   = RAM_WORDS + N_RANDOM + (LSQ_DEPTH + 2)
                                 + 3 * (LSQ_DEPTH - 2) + N_STALL + N_LONE;
    localparam int CYCLE_LIMIT = 20 * TOTAL_OPS + 200;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;  // x^32 + x^22 + x^2 + x + 1

    typedef logic [RAM_ADDR_W-1:0] ram_idx_t;
    typedef enum int {AGU_RANDOM, AGU_OFF, AGU_OLDEST, AGU_REVERSE} agu_mode_t;

    logic       clk;
    logic       rst;
    logic       ds_valid;
    logic       ds_ready;
    lsu_op_t    ds_op;
    rob_id_t    ds_rob_id;
    arch_reg_t  ds_rd_arch;
    phy_reg_t   ds_rd_phy;
    logic       agu_valid;
    rob_id_t    agu_rob_id;
    addr_t      agu_addr;
    byte_mask_t agu_mask;
    word_t      agu_wdata;
    logic       cdb_valid;
    logic       cdb_ready;
    lsu_op_t    cdb_op;
    rob_id_t    cdb_rob_id;
    arch_reg_t  cdb_rd_arch;
    phy_reg_t   cdb_rd_phy;
    word_t      cdb_data;

    logic [31:0] lfsr;
    word_t       model_mem [RAM_WORDS];  // Memory as program order leaves it
    rob_id_t     free_q [$];
    rob_id_t     pend_rob [$];           // Accepted ops still waiting for their AGU strobe
    addr_t       pend_addr [$];
    byte_mask_t  pend_mask [$];
    word_t       pend_wdata [$];
    lsu_op_t     exp_op_q [$];           // Expected CDB results in program order
    rob_id_t     exp_rob_q [$];
    arch_reg_t   exp_arch_q [$];
    phy_reg_t    exp_phy_q [$];
    word_t       exp_data_q [$];
    addr_t       cur_addr;
    byte_mask_t  cur_mask;
    word_t       cur_wdata;
    logic [48:0] held_cdb;

    string     cur_test;
    agu_mode_t agu_mode;
    bit        fill_mode;
    bit        dispatch_always;
    bit        stall_mode;
    bit        full_mode;
    bit        latency_mode;
    bit        full_seen;
    bit        refill_seen;
    bit        stalled_prev;
    bit        cdb_prev;
    bit        timed_out;
    int        dispatch_left;
    int        batch_total;
    int        batch_accepted;
    int        fill_idx;
    int        stall_left;
    int        cycle_count;
    int        last_strobe_edge;
    int        errors;
    int        errors_at_start;
    int        test_ops;
    int        tests_run;
    int        tests_ok;

    lsu_top #(
        .LSQ_DEPTH  (LSQ_DEPTH),
        .RAM_ADDR_W (RAM_ADDR_W)
    ) lsu_top_inst (
        .clk         (clk),
        .rst         (rst),
        .ds_valid    (ds_valid),
        .ds_ready    (ds_ready),
        .ds_op       (ds_op),
        .ds_rob_id   (ds_rob_id),
        .ds_rd_arch  (ds_rd_arch),
        .ds_rd_phy   (ds_rd_phy),
        .agu_valid   (agu_valid),
        .agu_rob_id  (agu_rob_id),
        .agu_addr    (agu_addr),
        .agu_mask    (agu_mask),
        .agu_wdata   (agu_wdata),
        .cdb_valid   (cdb_valid),
        .cdb_ready   (cdb_ready),
        .cdb_op      (cdb_op),
        .cdb_rob_id  (cdb_rob_id),
        .cdb_rd_arch (cdb_rd_arch),
        .cdb_rd_phy  (cdb_rd_phy),
        .cdb_data    (cdb_data)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    // One LFSR step per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return r;
    endfunction

    function automatic word_t mask_bytes(input word_t w, input byte_mask_t m);
        word_t r;
        for (int i = 0; i < 4; i++) begin
            r[8*i +: 8] = m[i] ? w[8*i +: 8] : 8'h00;
        end
        return r;
    endfunction

    function automatic logic [48:0] cdb_word();
        return {cdb_op, cdb_rob_id, cdb_rd_arch, cdb_rd_phy, cdb_data};
    endfunction

    task automatic check_rob(input string what, input rob_id_t exp, input rob_id_t act);
        if (act !== exp) begin
            $display("Error %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_arch(input string what, input arch_reg_t exp, input arch_reg_t act);
        if (act !== exp) begin
            $display("Error %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_phy(input string what, input phy_reg_t exp, input phy_reg_t act);
        if (act !== exp) begin
            $display("Error %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_op(input string what, input lsu_op_t exp, input lsu_op_t act);
        if (act !== exp) begin
            $display("Error %s %s: expected %s, actual %s", cur_test, what, exp.name(),
                     act.name());
            errors++;
        end
    endtask

    // Makes up the next op and applies it to the model in program order
    task automatic dispatch_new_op();
        lsu_op_t    op;
        ram_idx_t   idx;
        byte_mask_t mask;
        word_t      wdata;
        rob_id_t    rob;
        arch_reg_t  rd_arch;
        phy_reg_t   rd_phy;
        op    = rand_bits(1) ? LSU_STORE : LSU_LOAD;
        idx   = ram_idx_t'(rand_bits(RAM_ADDR_W));
        mask  = byte_mask_t'(rand_bits(4));
        wdata = rand_bits(32);
        if (mask == '0) mask = 4'hf;
        if (fill_mode) begin
            op   = LSU_STORE;
            idx  = ram_idx_t'(fill_idx);
            mask = 4'hf;
            fill_idx++;
        end
        rob = free_q.pop_front();
        if (op == LSU_STORE) begin
            for (int i = 0; i < 4; i++) begin
                if (mask[i]) model_mem[idx][8*i +: 8] = wdata[8*i +: 8];
            end
            exp_data_q.push_back('0);
        end else begin
            exp_data_q.push_back(mask_bytes(model_mem[idx], mask));
        end
        exp_op_q.push_back(op);
        exp_rob_q.push_back(rob);
        cur_addr   = {{(30 - RAM_ADDR_W){1'b0}}, idx, 2'b00};
        cur_mask   = mask;
        cur_wdata  = wdata;
        rd_arch    = arch_reg_t'(rand_bits(ARCH_REG_W));
        rd_phy     = phy_reg_t'(rand_bits(PHY_REG_W));
        exp_arch_q.push_back(rd_arch);
        exp_phy_q.push_back(rd_phy);
        ds_valid   <= 1'b1;
        ds_op      <= op;
        ds_rob_id  <= rob;
        ds_rd_arch <= rd_arch;
        ds_rd_phy  <= rd_phy;
        dispatch_left--;
    endtask

    task automatic step_cycle();
        int pick;
        @(posedge clk);
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) timed_out = 1'b1;

        // Values read here are the ones the DUT saw on this edge
        if (ds_valid && ds_ready) begin
            pend_rob.push_back(ds_rob_id);
            pend_addr.push_back(cur_addr);
            pend_mask.push_back(cur_mask);
            pend_wdata.push_back(cur_wdata);
            batch_accepted++;
        end
        if (full_mode && !full_seen && ds_valid && !ds_ready) begin
            full_seen = 1'b1;
            agu_mode  = AGU_OLDEST;  // Let the head drain now
            if (batch_accepted != LSQ_DEPTH) begin
                $display("Error %s: expected %0d ops accepted before ds_ready fell, actual %0d",
                         cur_test, LSQ_DEPTH, batch_accepted);
                errors++;
            end
        end
        if (full_mode && full_seen && ds_ready) refill_seen = 1'b1;
        if (stalled_prev && (!cdb_valid || cdb_word() !== held_cdb)) begin
            $display("%s: the CDB output changed while cdb_ready was low", cur_test);
            errors++;
        end
        if (agu_mode == AGU_REVERSE && pend_rob.size() > 0 && cdb_valid) begin
            $display("%s: a result reached the CDB before the head had its address", cur_test);
            errors++;
        end
        if (latency_mode && cdb_valid && !cdb_prev
                && (cycle_count - 1 - last_strobe_edge) != 2) begin
            $display("Error %s: expected cdb_valid 2 cycles after the AGU strobe, actual %0d",
                     cur_test, cycle_count - 1 - last_strobe_edge);
            errors++;
        end
        if (cdb_valid && cdb_ready) begin
            if (exp_rob_q.size() == 0) begin
                $display("%s: the CDB delivered a result that no op was waiting for", cur_test);
                errors++;
            end else begin
                check_op("op", exp_op_q[0], cdb_op);
                check_rob("rob_id", exp_rob_q[0], cdb_rob_id);
                check_arch("rd_arch", exp_arch_q[0], cdb_rd_arch);
                check_phy("rd_phy", exp_phy_q[0], cdb_rd_phy);
                if (exp_op_q[0] == LSU_LOAD) check_word("load data", exp_data_q[0], cdb_data);
                free_q.push_back(exp_rob_q[0]);
                void'(exp_op_q.pop_front());
                void'(exp_rob_q.pop_front());
                void'(exp_arch_q.pop_front());
                void'(exp_phy_q.pop_front());
                void'(exp_data_q.pop_front());
            end
        end
        stalled_prev = cdb_valid && !cdb_ready;
        held_cdb     = cdb_word();
        cdb_prev     = cdb_valid;

        // A dispatch that was not taken stays on the port unchanged
        if (!(ds_valid && !ds_ready)) begin
            if (dispatch_left > 0 && free_q.size() > 0 && (dispatch_always || rand_bits(2) != 0))
                dispatch_new_op();
            else
                ds_valid <= 1'b0;
        end

        pick = -1;
        if (pend_rob.size() > 0) begin
            case (agu_mode)
                AGU_RANDOM:  if (rand_bits(1) != 0) pick = int'(rand_bits(4)) % pend_rob.size();
                AGU_OLDEST:  pick = 0;
                AGU_REVERSE: if (batch_accepted == batch_total) pick = pend_rob.size() - 1;
                default:     pick = -1;
            endcase
        end
        agu_valid <= 1'b0;
        if (pick >= 0) begin
            agu_valid  <= 1'b1;
            agu_rob_id <= pend_rob[pick];
            agu_addr   <= pend_addr[pick];
            agu_mask   <= pend_mask[pick];
            agu_wdata  <= pend_wdata[pick];
            pend_rob.delete(pick);
            pend_addr.delete(pick);
            pend_mask.delete(pick);
            pend_wdata.delete(pick);
            last_strobe_edge = cycle_count + 1;  // Edge that samples the strobe
        end

        if (stall_mode && stall_left > 0) begin
            cdb_ready <= 1'b0;
            stall_left--;
        end else begin
            cdb_ready <= 1'b1;
            if (stall_mode && rand_bits(2) == 0) stall_left = int'(rand_bits(3));
        end
    endtask

    task automatic run_batch(input int n);
        dispatch_left  = n;
        batch_total    = n;
        batch_accepted = 0;
        test_ops      += n;
        while (!timed_out && (batch_accepted < batch_total || exp_rob_q.size() > 0)) begin
            step_cycle();
        end
    endtask

    task automatic begin_test(input string name);
        cur_test        = name;
        errors_at_start = errors;
        test_ops        = 0;
        agu_mode        = AGU_RANDOM;
        fill_mode       = 1'b0;
        dispatch_always = 1'b0;
        stall_mode      = 1'b0;
        full_mode       = 1'b0;
        latency_mode    = 1'b0;
        full_seen       = 1'b0;
        refill_seen     = 1'b0;
        stall_left      = 0;
    endtask

    task automatic end_test();
        int n_err;
        n_err = errors - errors_at_start;
        tests_run++;
        if (timed_out) begin
            $display("test %s: timed out after %0d cycles, %0d results never arrived",
                     cur_test, cycle_count, exp_rob_q.size());
        end else if (n_err == 0) begin
            tests_ok++;
            $display("test %s: ok, %0d ops", cur_test, test_ops);
        end else begin
            $display("test %s: %0d errors in %0d ops", cur_test, n_err, test_ops);
        end
    endtask

    initial begin
        lfsr       = 32'h1f6e7947;
        clk        = 1'b0;
        rst        = 1'b1;
        ds_valid   = 1'b0;
        ds_op      = LSU_LOAD;
        ds_rob_id  = '0;
        ds_rd_arch = '0;
        ds_rd_phy  = '0;
        agu_valid  = 1'b0;
        agu_rob_id = '0;
        agu_addr   = '0;
        agu_mask   = '0;
        agu_wdata  = '0;
        cdb_ready  = 1'b1;
        errors     = 0;
        tests_run  = 0;
        tests_ok   = 0;
        timed_out  = 1'b0;
        cycle_count  = 0;
        stalled_prev = 1'b0;
        cdb_prev     = 1'b0;
        for (int i = 0; i < (1 << ROB_ID_W); i++) begin
            free_q.push_back(rob_id_t'(i));
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        if (!ds_ready || cdb_valid) begin
            $display("After reset ds_ready should be high and cdb_valid low");
            errors++;
        end

        // Every word is written once so later loads never see undefined RAM
        begin_test("memory_fill");
        fill_mode = 1'b1;
        fill_idx  = 0;
        run_batch(RAM_WORDS);
        end_test();

        if (!timed_out) begin
            begin_test("random_mix");
            run_batch(N_RANDOM);
            end_test();
        end

        if (!timed_out) begin
            begin_test("queue_full");
            full_mode       = 1'b1;
            dispatch_always = 1'b1;
            agu_mode        = AGU_OFF;
            run_batch(LSQ_DEPTH + 2);
            if (!timed_out && !(full_seen && refill_seen)) begin
                $display("%s: ds_ready did not fall on a full queue or did not rise again",
                         cur_test);
                errors++;
            end
            end_test();
        end

        if (!timed_out) begin
            begin_test("reverse_agu");
            dispatch_always = 1'b1;
            agu_mode        = AGU_REVERSE;
            repeat (3) run_batch(LSQ_DEPTH - 2);
            end_test();
        end

        if (!timed_out) begin
            begin_test("cdb_stall");
            stall_mode = 1'b1;
            run_batch(N_STALL);
            end_test();
        end

        if (!timed_out) begin
            begin_test("lone_latency");
            dispatch_always = 1'b1;
            latency_mode    = 1'b1;
            agu_mode        = AGU_OLDEST;
            repeat (N_LONE) run_batch(1);
            end_test();
        end

        $display("%0d tests run, %0d ok, %0d with errors, %0d errors in total",
                 tests_run, tests_ok, tests_run - tests_ok, errors);
        if (errors == 0 && !timed_out) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
